// ==== common/mcu_bridge_pkg.sv ====
package mcu_bridge_pkg;

    localparam int reg_width = 32;
    localparam int mem_data_width = 16;
    localparam int mem_address_width = 32;
    localparam int buffer_index_width = 9;
    localparam int spi_byte_width = 8;

    localparam logic [7:0] fpga_id = 8'h64;
    localparam logic [31:0] cfg_version = 32'h53437632;

    typedef enum logic [7:0] {
        cmd_identify = 8'd0,
        cmd_reg_read = 8'd1,
        cmd_reg_write = 8'd2,
        cmd_mem_read = 8'd3,
        cmd_mem_write = 8'd4
    } cmd_e;

    typedef enum logic [1:0] {
        phase_cmd,
        phase_address,
        phase_data,
        phase_nop
    } phase_e;

    typedef enum logic [7:0] {
        reg_mem_address = 8'd0,
        reg_mem_scr = 8'd1,
        reg_cfg_scr = 8'd2,
        reg_cfg_version = 8'd3
    } reg_address_e;

endpackage

// ==== rtl/mcu_spi.sv ====
`timescale 1ns/10ps

module mcu_spi #(
    parameter int sync_stages = 3
) (
    input clk,
    input reset,

    input mcu_clk,
    input mcu_cs,
    input mcu_mosi,
    output logic mcu_miso,

    output logic frame_start,
    output logic data_ready,
    output logic [mcu_bridge_pkg::spi_byte_width-1:0] rx_data,
    input [mcu_bridge_pkg::spi_byte_width-1:0] tx_data
);

    logic [sync_stages-1:0] sck_ff;
    logic [sync_stages-1:0] cs_ff;
    logic [sync_stages-1:0] mosi_ff;
    logic sck_prev;
    logic cs_prev;

    logic sck_rising;
    logic sck_falling;
    logic cs_falling;
    logic cs_active;

    logic [2:0] bit_count;
    logic [1:0] load_pipe;
    logic [mcu_bridge_pkg::spi_byte_width-1:0] rx_shift;
    logic [mcu_bridge_pkg::spi_byte_width-1:0] tx_shift;

    assign sck_rising = sck_ff[sync_stages-1] && !sck_prev;
    assign sck_falling = !sck_ff[sync_stages-1] && sck_prev;
    assign cs_falling = !cs_ff[sync_stages-1] && cs_prev;
    assign cs_active = !cs_ff[sync_stages-1];

    assign rx_data = rx_shift;
    assign mcu_miso = tx_shift[mcu_bridge_pkg::spi_byte_width-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            sck_ff <= '0;
            cs_ff <= '1; // Link idles deselected
            mosi_ff <= '0;
            sck_prev <= 1'b0;
            cs_prev <= 1'b1;
            bit_count <= 3'd0;
            frame_start <= 1'b0;
            data_ready <= 1'b0;
            load_pipe <= 2'b00;
        end else begin
            sck_ff <= {sck_ff[sync_stages-2:0], mcu_clk};
            cs_ff <= {cs_ff[sync_stages-2:0], mcu_cs};
            mosi_ff <= {mosi_ff[sync_stages-2:0], mcu_mosi};
            sck_prev <= sck_ff[sync_stages-1];
            cs_prev <= cs_ff[sync_stages-1];

            frame_start <= cs_falling;
            data_ready <= 1'b0;
            load_pipe <= {load_pipe[0], data_ready || frame_start}; // Gives protocol time to fetch

            if (cs_active) begin
                if (sck_rising) begin
                    bit_count <= bit_count + 3'd1;
                    data_ready <= (bit_count == 3'd7);
                end
            end else begin
                bit_count <= 3'd0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cs_active && sck_rising) begin
            rx_shift <= {rx_shift[mcu_bridge_pkg::spi_byte_width-2:0], mosi_ff[sync_stages-1]};
        end

        if (load_pipe[1]) begin
            tx_shift <= tx_data;
        end else if (cs_active && sck_falling && (bit_count != 3'd0)) begin
            tx_shift <= tx_shift << 1; // Trailing edge of a byte keeps the reloaded MSB
        end
    end

    assert property (@(posedge clk) disable iff (reset) data_ready |=> !data_ready);

endmodule

// ==== rtl/mcu_protocol.sv ====
`timescale 1ns/10ps

module mcu_protocol (
    input clk,
    input reset,

    input frame_start,
    input data_ready,
    input [mcu_bridge_pkg::spi_byte_width-1:0] rx_data,
    output logic [mcu_bridge_pkg::spi_byte_width-1:0] tx_data,

    output logic reg_read,
    output logic reg_write,
    output logic [7:0] reg_address,
    output logic [mcu_bridge_pkg::reg_width-1:0] reg_wdata,
    input [mcu_bridge_pkg::reg_width-1:0] reg_rdata,

    output logic buf_read,
    output logic buf_write,
    output logic [mcu_bridge_pkg::buffer_index_width-1:0] buf_index,
    output logic [mcu_bridge_pkg::mem_data_width-1:0] buf_wdata,
    input [mcu_bridge_pkg::mem_data_width-1:0] buf_rdata
);

    mcu_bridge_pkg::phase_e phase;
    mcu_bridge_pkg::cmd_e cmd;

    logic [1:0] counter;
    logic [7:0] address;
    logic word_select;

    assign reg_address = address;
    assign buf_index = {address, word_select}; // Two 16-bit words per address step

    always_ff @(posedge clk) begin
        reg_read <= 1'b0;
        reg_write <= 1'b0;
        buf_read <= 1'b0;
        buf_write <= 1'b0;

        if (reset) begin
            phase <= mcu_bridge_pkg::phase_cmd;
            cmd <= mcu_bridge_pkg::cmd_identify;
            counter <= 2'd0;
            word_select <= 1'b0;
        end else begin
            if (frame_start) begin
                counter <= 2'd0;
                phase <= mcu_bridge_pkg::phase_cmd;
            end

            if (reg_read || reg_write || (word_select && (buf_read || buf_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    mcu_bridge_pkg::phase_cmd: begin
                        cmd <= mcu_bridge_pkg::cmd_e'(rx_data);
                        if (rx_data > mcu_bridge_pkg::cmd_mem_write) begin
                            phase <= mcu_bridge_pkg::phase_nop; // Unknown command, rest of frame ignored
                        end else begin
                            phase <= mcu_bridge_pkg::phase_address;
                        end
                    end

                    mcu_bridge_pkg::phase_address: begin
                        address <= rx_data;
                        phase <= mcu_bridge_pkg::phase_data;
                        if (cmd == mcu_bridge_pkg::cmd_reg_read) begin
                            reg_read <= 1'b1;
                        end
                        if (cmd == mcu_bridge_pkg::cmd_mem_read) begin
                            buf_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    mcu_bridge_pkg::phase_data: begin
                        counter <= counter + 2'd1;

                        if ((cmd == mcu_bridge_pkg::cmd_reg_read) && (counter == 2'd3)) begin
                            reg_read <= 1'b1;
                        end

                        if (cmd == mcu_bridge_pkg::cmd_reg_write) begin
                            reg_wdata[{counter, 3'b000} +: 8] <= rx_data;
                            reg_write <= (counter == 2'd3);
                        end

                        if ((cmd == mcu_bridge_pkg::cmd_mem_read) && counter[0]) begin
                            buf_read <= 1'b1;
                            word_select <= ~word_select;
                        end

                        if (cmd == mcu_bridge_pkg::cmd_mem_write) begin
                            if (counter[0]) begin
                                buf_wdata[7:0] <= rx_data;
                                buf_write <= 1'b1;
                                word_select <= counter[1];
                            end else begin
                                buf_wdata[15:8] <= rx_data;
                            end
                        end
                    end

                    default: begin
                    end
                endcase
            end
        end
    end

    always_comb begin
        tx_data = 8'h00;

        if (phase != mcu_bridge_pkg::phase_cmd) begin
            case (cmd)
                mcu_bridge_pkg::cmd_identify: tx_data = mcu_bridge_pkg::fpga_id;
                mcu_bridge_pkg::cmd_reg_read: begin
                    if (phase == mcu_bridge_pkg::phase_data) begin
                        tx_data = reg_rdata[{counter, 3'b000} +: 8];
                    end
                end
                mcu_bridge_pkg::cmd_mem_read: begin
                    if (phase == mcu_bridge_pkg::phase_data) begin
                        tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
                    end
                end
                default: tx_data = 8'h00;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(reg_read && reg_write));

endmodule

// ==== rtl/mcu_registers.sv ====
`timescale 1ns/10ps

module mcu_registers #(
    parameter int sync_stages = 3
) (
    input clk,
    input reset,

    input button,

    input reg_read,
    input reg_write,
    input [7:0] reg_address,
    input [mcu_bridge_pkg::reg_width-1:0] reg_wdata,
    output logic [mcu_bridge_pkg::reg_width-1:0] reg_rdata,

    output logic dma_start,
    output logic dma_stop,
    output logic dma_direction,
    output logic [mcu_bridge_pkg::buffer_index_width-1:0] dma_length,
    output logic [mcu_bridge_pkg::mem_address_width-1:0] dma_address,
    input dma_busy,

    output logic [7:0] cfg_flags
);

    logic [sync_stages-1:0] button_ff;
    logic [9:0] length_minus_one;

    assign length_minus_one = reg_wdata[14:5] - 10'd1; // Count of 512 wraps to index 511

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[sync_stages-2:0], button};
    end

    always_ff @(posedge clk) begin
        if (reg_read) begin
            case (mcu_bridge_pkg::reg_address_e'(reg_address))
                mcu_bridge_pkg::reg_mem_address: reg_rdata <= dma_address;
                mcu_bridge_pkg::reg_mem_scr: reg_rdata <= {28'd0, dma_busy, 3'b000};
                mcu_bridge_pkg::reg_cfg_scr: begin
                    reg_rdata <= {~button_ff[sync_stages-1], 23'd0, cfg_flags}; // Button is active low
                end
                mcu_bridge_pkg::reg_cfg_version: reg_rdata <= mcu_bridge_pkg::cfg_version;
                default: reg_rdata <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        dma_start <= 1'b0;
        dma_stop <= 1'b0;

        if (reset) begin
            cfg_flags <= 8'h01;
            dma_direction <= 1'b0;
        end else if (reg_write) begin
            case (mcu_bridge_pkg::reg_address_e'(reg_address))
                mcu_bridge_pkg::reg_mem_address: dma_address <= reg_wdata;
                mcu_bridge_pkg::reg_mem_scr: begin
                    dma_start <= reg_wdata[0];
                    dma_stop <= reg_wdata[1];
                    dma_direction <= reg_wdata[2];
                    dma_length <= length_minus_one[8:0];
                end
                mcu_bridge_pkg::reg_cfg_scr: cfg_flags <= reg_wdata[7:0];
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== mem/mem_buffer_dma.sv ====
`timescale 1ns/10ps

module mem_buffer_dma (
    input clk,
    input reset,

    input buf_read,
    input buf_write,
    input [mcu_bridge_pkg::buffer_index_width-1:0] buf_index,
    input [mcu_bridge_pkg::mem_data_width-1:0] buf_wdata,
    output logic [mcu_bridge_pkg::mem_data_width-1:0] buf_rdata,

    input dma_start,
    input dma_stop,
    input dma_direction,
    input [mcu_bridge_pkg::buffer_index_width-1:0] dma_length,
    input [mcu_bridge_pkg::mem_address_width-1:0] dma_address,
    output logic dma_busy,

    output logic mem_request,
    output logic mem_write,
    output logic [mcu_bridge_pkg::mem_address_width-1:0] mem_address,
    output logic [mcu_bridge_pkg::mem_data_width-1:0] mem_wdata,
    input mem_ack,
    input [mcu_bridge_pkg::mem_data_width-1:0] mem_rdata
);

    localparam int buffer_depth = 2 ** mcu_bridge_pkg::buffer_index_width;

    logic [mcu_bridge_pkg::mem_data_width-1:0] buffer [0:buffer_depth-1];

    logic stop_pending;
    logic [mcu_bridge_pkg::buffer_index_width-1:0] dma_index;

    always_ff @(posedge clk) begin
        if (buf_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (buf_write) begin
            buffer[buf_index] <= buf_wdata;
        end
        if (dma_busy && mem_request && mem_ack && !mem_write) begin
            buffer[dma_index] <= mem_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dma_busy <= 1'b0;
            stop_pending <= 1'b0;
            mem_request <= 1'b0;
        end else begin
            if (dma_stop) begin
                stop_pending <= dma_busy;
            end else if (dma_start && !dma_busy) begin
                mem_write <= dma_direction;
                mem_address <= dma_address;
                dma_index <= '0;
                dma_busy <= 1'b1;
            end

            if (dma_busy) begin
                if (mem_request) begin
                    if (mem_ack) begin
                        mem_request <= 1'b0;
                        mem_address <= mem_address + 32'd2;
                        dma_index <= dma_index + 9'd1;
                        if ((dma_index == dma_length) || stop_pending) begin
                            dma_busy <= 1'b0;
                            stop_pending <= 1'b0;
                        end
                    end
                end else if (stop_pending) begin
                    dma_busy <= 1'b0;
                    stop_pending <= 1'b0;
                end else if (!mem_ack) begin
                    mem_request <= 1'b1; // Previous ack has to clear first
                    mem_wdata <= buffer[dma_index];
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=> mem_request);

endmodule

// ==== rtl/mcu_bridge_top.sv ====
`timescale 1ns/10ps

module mcu_bridge_top #(
    parameter int sync_stages = 3
) (
    input clk,
    input reset,

    input button,

    input mcu_clk,
    input mcu_cs,
    input mcu_mosi,
    output logic mcu_miso,

    output logic mem_request,
    output logic mem_write,
    output logic [mcu_bridge_pkg::mem_address_width-1:0] mem_address,
    output logic [mcu_bridge_pkg::mem_data_width-1:0] mem_wdata,
    input mem_ack,
    input [mcu_bridge_pkg::mem_data_width-1:0] mem_rdata,

    output logic [7:0] cfg_flags
);

    logic frame_start;
    logic data_ready;
    logic [mcu_bridge_pkg::spi_byte_width-1:0] rx_data;
    logic [mcu_bridge_pkg::spi_byte_width-1:0] tx_data;

    logic reg_read;
    logic reg_write;
    logic [7:0] reg_address;
    logic [mcu_bridge_pkg::reg_width-1:0] reg_wdata;
    logic [mcu_bridge_pkg::reg_width-1:0] reg_rdata;

    logic buf_read;
    logic buf_write;
    logic [mcu_bridge_pkg::buffer_index_width-1:0] buf_index;
    logic [mcu_bridge_pkg::mem_data_width-1:0] buf_wdata;
    logic [mcu_bridge_pkg::mem_data_width-1:0] buf_rdata;

    logic dma_start;
    logic dma_stop;
    logic dma_direction;
    logic [mcu_bridge_pkg::buffer_index_width-1:0] dma_length;
    logic [mcu_bridge_pkg::mem_address_width-1:0] dma_address;
    logic dma_busy;

    mcu_spi #(
        .sync_stages(sync_stages)
    ) mcu_spi_inst (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data)
    );

    mcu_protocol mcu_protocol_inst (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .tx_data(tx_data),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .buf_rdata(buf_rdata)
    );

    mcu_registers #(
        .sync_stages(sync_stages)
    ) mcu_registers_inst (
        .clk(clk),
        .reset(reset),
        .button(button),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata),
        .dma_start(dma_start),
        .dma_stop(dma_stop),
        .dma_direction(dma_direction),
        .dma_length(dma_length),
        .dma_address(dma_address),
        .dma_busy(dma_busy),
        .cfg_flags(cfg_flags)
    );

    mem_buffer_dma mem_buffer_dma_inst (
        .clk(clk),
        .reset(reset),
        .buf_read(buf_read),
        .buf_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .buf_rdata(buf_rdata),
        .dma_start(dma_start),
        .dma_stop(dma_stop),
        .dma_direction(dma_direction),
        .dma_length(dma_length),
        .dma_address(dma_address),
        .dma_busy(dma_busy),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

endmodule

// ==== test/tb_mcu_bridge.sv ====
`timescale 1ns/10ps

module tb_mcu_bridge;

    localparam int half_period_clks = 8; // SPI half period in clk cycles
    localparam int byte_gap_clks = 8;
    localparam int poll_limit = 40;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic button = 1'b0;
    logic mcu_clk = 1'b0;
    logic mcu_cs = 1'b1;
    logic mcu_mosi = 1'b0;
    logic mcu_miso;
    logic mem_request;
    logic mem_write;
    logic [31:0] mem_address;
    logic [15:0] mem_wdata;
    logic mem_ack = 1'b0;
    logic [15:0] mem_rdata = 16'h0000;
    logic [7:0] cfg_flags;

    logic [15:0] memory [bit [31:0]]; // Words written by the DMA
    logic [15:0] preload_words [bit [31:0]];
    logic [31:0] lfsr_state = 32'h78ec621f;
    logic [1:0] ack_delay;
    logic delay_armed;

    logic [7:0] frame_send [0:31];
    logic [7:0] frame_expect [0:31];
    logic [7:0] frame_got [0:31];
    logic frame_care [0:31];

    int error_count = 0;
    int check_count = 0;

    mcu_bridge_top #(
        .sync_stages(3)
    ) mcu_bridge_top_inst (
        .clk(clk),
        .reset(reset),
        .button(button),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .mem_request(mem_request),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .cfg_flags(cfg_flags)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [15:0] read_word(input logic [31:0] address);
        if (memory.exists(address)) begin
            return memory[address];
        end else if (preload_words.exists(address)) begin
            return preload_words[address];
        end
        return address[31:16] ^ address[15:0] ^ 16'h5a5a;
    endfunction

    // Four-phase slave with 0 to 3 cycles before each ack
    always @(posedge clk) begin
        if (reset) begin
            mem_ack <= 1'b0;
            delay_armed = 1'b0;
        end else if (mem_ack) begin
            if (!mem_request) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_request) begin
            if (!delay_armed) begin
                lfsr_state = lfsr_next(lfsr_state);
                ack_delay[1] = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
                ack_delay[0] = lfsr_state[0];
                delay_armed = 1'b1;
            end
            if (ack_delay == 2'd0) begin
                mem_ack <= 1'b1;
                if (mem_write) begin
                    memory[mem_address] = mem_wdata;
                end else begin
                    mem_rdata <= read_word(mem_address);
                end
                delay_armed = 1'b0;
            end else begin
                ack_delay = ack_delay - 2'd1;
            end
        end
    end

    task automatic spi_transfer_byte(input logic [7:0] send, output logic [7:0] received);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi <= send[i];
            repeat (half_period_clks) @(posedge clk);
            received[i] = mcu_miso; // Mode 0 master samples on the rising edge
            mcu_clk <= 1'b1;
            repeat (half_period_clks) @(posedge clk);
            mcu_clk <= 1'b0;
        end
        repeat (byte_gap_clks) @(posedge clk);
    endtask

    task automatic run_frame(input int count);
        logic [7:0] got;
        mcu_cs <= 1'b0;
        repeat (2 * half_period_clks) @(posedge clk);
        for (int k = 0; k < count; k++) begin
            spi_transfer_byte(frame_send[k], got);
            frame_got[k] = got;
        end
        mcu_cs <= 1'b1;
        repeat (2 * half_period_clks) @(posedge clk);
    endtask

    task automatic compare_frame(input int count);
        for (int k = 0; k < count; k++) begin
            if (frame_care[k]) begin
                check_count++;
                if (frame_got[k] !== frame_expect[k]) begin
                    error_count++;
                    $display("[FAIL] %0t: mcu_miso byte %0d expected %02h got %02h",
                             $time, k, frame_expect[k], frame_got[k]);
                end
            end
        end
    endtask

    task automatic poll_dma_idle;
        int polls;
        logic idle;
        polls = 0;
        idle = 1'b0;
        while (!idle && (polls < poll_limit)) begin
            frame_send[0] = 8'h01;
            frame_send[1] = 8'h01; // Memory status register
            for (int k = 2; k < 6; k++) begin
                frame_send[k] = 8'h00;
            end
            run_frame(6);
            idle = !frame_got[2][3];
            polls++;
        end
        check_count++;
        if (!idle) begin
            error_count++;
            $display("DMA still busy after %0d status polls at %0t", poll_limit, $time);
        end
    endtask

    initial begin : trace_player
        int fd;
        int code;
        int count;
        logic [8*12-1:0] keyword;
        logic [15:0] token;
        logic [8*256-1:0] rest_of_line;
        logic [31:0] address;
        logic [31:0] value;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        check_count++;
        if (mem_request !== 1'b0) begin
            error_count++;
            $display("[FAIL] %0t: mem_request expected 0 got %b", $time, mem_request);
        end

        fd = $fopen("test/mcu_bridge_trace.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Cannot open the trace file test/mcu_bridge_trace.txt");
        end else begin
            while ($fscanf(fd, "%s", keyword) == 1) begin
                if (keyword == "#") begin
                    code = $fgets(rest_of_line, fd);
                end else if (keyword == "frame") begin
                    code = $fscanf(fd, "%d", count);
                    for (int k = 0; k < count; k++) begin
                        code = $fscanf(fd, "%h %s", value, token);
                        frame_send[k] = value[7:0];
                        frame_care[k] = (token != "xx"); // Don't care slot
                        code = $sscanf(token, "%h", value);
                        frame_expect[k] = value[7:0];
                    end
                    run_frame(count);
                    compare_frame(count);
                end else if (keyword == "poll") begin
                    poll_dma_idle();
                end else if (keyword == "button") begin
                    code = $fscanf(fd, "%h", value);
                    button <= value[0];
                end else if (keyword == "flags") begin
                    code = $fscanf(fd, "%h", value);
                    check_count++;
                    if (cfg_flags !== value[7:0]) begin
                        error_count++;
                        $display("[FAIL] %0t: cfg_flags expected %02h got %02h",
                                 $time, value[7:0], cfg_flags);
                    end
                end else if (keyword == "preload") begin
                    code = $fscanf(fd, "%h %h", address, value);
                    preload_words[address] = value[15:0];
                end else if (keyword == "memcheck") begin
                    code = $fscanf(fd, "%h %h", address, value);
                    check_count++;
                    if (!memory.exists(address)) begin
                        error_count++;
                        $display("Memory word at %08h was never written by the DMA", address);
                    end else if (memory[address] !== value[15:0]) begin
                        error_count++;
                        $display("[FAIL] %0t: memory[%08h] expected %04h got %04h",
                                 $time, address, value[15:0], memory[address]);
                    end
                end else begin
                    error_count++;
                    $display("Unknown command in the trace file: %0s", keyword);
                end
            end
            $fclose(fd);
        end

        if (check_count == 0) begin
            error_count++;
            $display("The trace file held no checks");
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== test/mcu_bridge_trace.txt ====
# frame <n> then n pairs of <sent byte> <expected byte or xx>; poll; button <level>
# flags <hex>; preload <address> <word>; memcheck <address> <word>; values in hex
flags 01
frame 4 00 00 00 64 00 64 00 64
frame 6 01 00 03 00 00 32 00 76 00 43 00 53
frame 6 01 00 02 00 00 01 00 00 00 00 00 80
frame 6 02 00 02 00 a5 00 00 00 00 00 00 00
flags a5
frame 6 01 00 02 00 00 a5 00 00 00 00 00 80
button 1
frame 6 01 00 02 00 00 a5 00 00 00 00 00 00
button 0
frame 10 04 00 10 00 12 00 34 00 ab 00 cd 00 5a 00 5a 00 0f 00 0e 00
frame 10 03 00 10 00 00 12 00 34 00 ab 00 cd 00 5a 00 5a 00 0f 00 0e
frame 10 04 00 00 00 c0 00 01 00 d0 00 0d 00 be 00 ef 00 7e 00 57 00
frame 10 02 00 00 00 00 00 10 00 00 00 00 00 85 00 00 00 00 00 00 00
poll
memcheck 00001000 c001
memcheck 00001002 d00d
memcheck 00001004 beef
memcheck 00001006 7e57
frame 10 01 00 00 00 00 00 00 10 00 00 00 00 00 00 00 00 00 00 00 00
frame 6 01 xx 05 xx 00 00 00 00 00 00 00 00
preload 00002000 1357
preload 00002002 2468
preload 00002004 9abc
frame 10 02 00 00 00 00 00 20 00 00 00 00 00 61 00 00 00 00 00 00 00
poll
frame 10 03 00 00 00 00 13 00 57 00 24 00 68 00 9a 00 bc 00 7e 00 57

// ==== list.f ====
common/mcu_bridge_pkg.sv
rtl/mcu_spi.sv
rtl/mcu_protocol.sv
rtl/mcu_registers.sv
mem/mem_buffer_dma.sv
rtl/mcu_bridge_top.sv
test/tb_mcu_bridge.sv

// ==== run.sh ====
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_mcu_bridge -o sim_mcu_bridge

output=$(./obj_dir/sim_mcu_bridge)
echo "$output"

if grep -q "TEST PASSED" <<< "$output"; then
    exit 0
fi
exit 1
